// ==== run_sim.sh ====
#!/bin/sh
# Build and run the dsp_core testbench with Verilator.

cd "$(dirname "$0")" || exit 1

log=sim.log
obj=obj_dir

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module dsp_core_tb -Mdir "$obj" -o dsp_core_sim -f sources.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$obj/dsp_core_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$log"; then
    echo "fail message found in $log"
    exit 1
fi
exit 0

// ==== sources.f ====
verilog/dsp_mem_pkg.sv
verilog/dsp_cmd_pkg.sv
verilog/sample_link_if.sv
verilog/aligned_ram.sv
verilog/pulse_sequencer.sv
verilog/sample_fifo.sv
verilog/dac_drive.sv
verilog/dsp_core.sv
tb/dsp_core_tb.sv

// ==== tb/dsp_core_tb.sv ====
`timescale 1ns/10ps

module dsp_core_tb;

    logic        clk;
    logic        reset;
    logic        stb_start;
    logic        mem_write_en;
    logic [2:0]  mem_write_sel;
    logic [15:0] mem_write_addr;
    logic [31:0] mem_write_data;
    logic        dac_ready;
    logic        dac_valid;
    logic [63:0] dac_data;
    logic        dac_last;
    logic        done;

    logic [63:0] env_copy [0:511];
    logic [31:0] cmd_copy [0:255];
    logic [64:0] exp_q [$];
    logic [63:0] head_data;
    logic        head_last;
    logic        head_empty = 1'b1;
    bit          stall_pat [0:4095];
    bit          stall_on;
    bit          started;
    int          pat_idx = 0;
    int          cycle = 0;
    int          deadline;
    int          gap_min;
    int          gap_cnt;
    int          data_errs = 0;
    int          proto_errs = 0;

    dsp_core dut_i (
        .clk(clk),
        .reset(reset),
        .stb_start(stb_start),
        .mem_write_en(mem_write_en),
        .mem_write_sel(mem_write_sel),
        .mem_write_addr(mem_write_addr),
        .mem_write_data(mem_write_data),
        .dac_ready(dac_ready),
        .dac_valid(dac_valid),
        .dac_data(dac_data),
        .dac_last(dac_last),
        .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (reset) begin
            gap_cnt <= 32'h7fff_ffff;
        end else if (dac_valid && dac_ready && dac_last) begin
            gap_cnt <= 1;
        end else if (gap_cnt != 32'h7fff_ffff) begin
            gap_cnt <= gap_cnt + 1;
        end
        if (!reset && dac_valid && dac_ready && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
        end
    end

    // head of the expected queue, settled away from the rising edge.
    always @(negedge clk) begin
        head_empty = (exp_q.size() == 0);
        if (!head_empty) begin
            {head_last, head_data} = exp_q[0];
        end
    end

    // about 40 percent of cycles stall the output when enabled.
    initial begin
        dac_ready = 1'b1;
        forever begin
            @(posedge clk);
            #1;
            if (stall_on) begin
                dac_ready = !stall_pat[pat_idx];
                pat_idx = (pat_idx + 1) % 4096;
            end else begin
                dac_ready = 1'b1;
            end
        end
    end

    initial begin
        while (deadline == 0 || cycle <= deadline) begin
            @(posedge clk);
        end
        $display("watchdog expired at cycle %0d before the run finished", cycle);
        $display("Test FAILED");
        $finish;
    end

    a_word_match: assert property (@(posedge clk) disable iff (reset)
        dac_valid && dac_ready && !head_empty |->
            dac_data == head_data && dac_last == head_last)
    else begin
        data_errs++;
        $display("error at %0t: dac word %h last %b, expected %h last %b", $time,
                 $sampled(dac_data), $sampled(dac_last), head_data, head_last);
    end

    a_no_extra: assert property (@(posedge clk) disable iff (reset)
        dac_valid && dac_ready |-> !head_empty)
    else begin
        proto_errs++;
        $display("a dac word transferred at %0t when none was expected", $time);
    end

    a_hold: assert property (@(posedge clk) disable iff (reset)
        dac_valid && !dac_ready |=> dac_valid && $stable(dac_data) && $stable(dac_last))
    else begin
        proto_errs++;
        $display("the dac word changed or vanished during a stall at %0t", $time);
    end

    a_quiet: assert property (@(posedge clk) disable iff (reset)
        !started |-> !dac_valid && !done)
    else begin
        proto_errs++;
        $display("dac_valid or done went high before the first start at %0t", $time);
    end

    a_wait_gap: assert property (@(posedge clk) disable iff (reset)
        dac_valid |-> gap_cnt >= gap_min)
    else begin
        data_errs++;
        $display("error at %0t: gap after wait was %0d cycles, expected at least %0d",
                 $time, $sampled(gap_cnt), gap_min);
    end

    a_done_late: assert property (@(posedge clk) disable iff (reset)
        $rose(done) |-> head_empty && !dac_valid)
    else begin
        proto_errs++;
        $display("done rose at %0t while words were still outstanding", $time);
    end

    a_done_holds: assert property (@(posedge clk) disable iff (reset)
        done && !stb_start |=> done)
    else begin
        proto_errs++;
        $display("done dropped at %0t without a new start", $time);
    end

    // Q0.15 scaling with floor rounding by an arithmetic shift right of 15.
    function automatic logic [63:0] scale_word(input logic [63:0] w, input logic [13:0] amp);
        logic [63:0] r;
        longint p;
        for (int i = 0; i < 4; i++) begin
            p = longint'($signed(w[i*16 +: 16])) * longint'(amp);
            r[i*16 +: 16] = 16'(p >>> 15);
        end
        return r;
    endfunction

    function automatic logic [31:0] play_cmd(input int addr, input int len,
                                             input logic [13:0] amp);
        return {dsp_cmd_pkg::OP_PLAY, 9'(addr), 7'(len), amp};
    endfunction

    function automatic logic [31:0] wait_cmd(input int n);
        return {dsp_cmd_pkg::OP_WAIT, 30'(n)};
    endfunction

    function automatic logic [31:0] end_cmd();
        return {dsp_cmd_pkg::OP_END, 30'd0};
    endfunction

    task automatic write_mem(input logic [2:0] sel, input int addr, input logic [31:0] data);
        @(posedge clk);
        #1;
        mem_write_en = 1'b1;
        mem_write_sel = sel;
        mem_write_addr = 16'(addr);
        mem_write_data = data;
        @(posedge clk);
        #1;
        mem_write_en = 1'b0;
    endtask

    task automatic load_env(input int base, input int count);
        logic [63:0] w;
        for (int i = 0; i < count; i++) begin
            w = {$urandom, $urandom};
            env_copy[9'(base + i)] = w;
            write_mem(dsp_mem_pkg::MEM_SEL_ENV, 2 * (base + i), w[31:0]);
            write_mem(dsp_mem_pkg::MEM_SEL_ENV, 2 * (base + i) + 1, w[63:32]);
        end
    endtask

    task automatic put_cmd(input int idx, input logic [31:0] w);
        cmd_copy[8'(idx)] = w;
        write_mem(dsp_mem_pkg::MEM_SEL_CMD, idx, w);
    endtask

    // walks the list from address 0 the way the sequencer should.
    task automatic build_expected(output int words, output int waits);
        logic [31:0] w;
        int pc;
        int len;
        int a;
        words = 0;
        waits = 0;
        pc = 0;
        while (pc < 256) begin
            w = cmd_copy[8'(pc)];
            pc++;
            if (w[31:30] == dsp_cmd_pkg::OP_PLAY) begin
                len = (w[20:14] == 7'd0) ? 128 : int'(w[20:14]);
                a = int'(w[29:21]);
                for (int k = 0; k < len; k++) begin
                    exp_q.push_back({k == len - 1, scale_word(env_copy[9'(a + k)], w[13:0])});
                end
                words += len;
            end else if (w[31:30] == dsp_cmd_pkg::OP_WAIT) begin
                waits += int'(w[29:0]);
            end else begin
                pc = 256;
            end
        end
    endtask

    task automatic run_list();
        int words;
        int waits;
        build_expected(words, waits);
        deadline = cycle + (words + waits + 100) * 4;
        @(posedge clk);
        #1;
        stb_start = 1'b1;
        started = 1'b1;
        @(posedge clk);
        #1;
        stb_start = 1'b0;
        while (!done) begin
            @(posedge clk);
            #1;
        end
        if (exp_q.size() != 0) begin
            proto_errs++;
            $display("%0d expected words never reached the dac port", exp_q.size());
        end
        repeat (20) @(posedge clk);
        #1;
        deadline = 0;
    endtask

    initial begin
        void'($urandom(95));
        reset = 1'b1;
        stb_start = 1'b0;
        mem_write_en = 1'b0;
        mem_write_sel = '0;
        mem_write_addr = '0;
        mem_write_data = '0;
        stall_on = 1'b0;
        started = 1'b0;
        deadline = 0;
        gap_min = 0;
        for (int i = 0; i < 4096; i++) begin
            stall_pat[i] = ($urandom_range(99) < 40);
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        // single play.
        load_env(0, 16);
        put_cmd(0, play_cmd(3, 6, 14'h2a51));
        put_cmd(1, end_cmd());
        run_list();

        // play, wait, play.
        put_cmd(0, play_cmd(0, 5, 14'h3fff));
        put_cmd(1, wait_cmd(40));
        put_cmd(2, play_cmd(8, 4, 14'h0c37));
        put_cmd(3, end_cmd());
        gap_min = 40;
        run_list();
        gap_min = 0;

        // long plays under random stall, the second one at full length.
        stall_on = 1'b1;
        load_env(16, 144);
        put_cmd(0, play_cmd(20, 20, 14'(int'($urandom_range(16383)))));
        put_cmd(1, play_cmd(30, 128, 14'(int'($urandom_range(16383)))));
        put_cmd(2, end_cmd());
        run_list();

        // reloaded memories give a new sequence.
        load_env(0, 16);
        put_cmd(0, play_cmd(5, 7, 14'(int'($urandom_range(16383)))));
        put_cmd(1, wait_cmd(3));
        put_cmd(2, play_cmd(0, 3, 14'h1000));
        put_cmd(3, end_cmd());
        run_list();

        $display("closing: %0d data errors, %0d protocol errors", data_errs, proto_errs);
        if (data_errs == 0 && proto_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== verilog/aligned_ram.sv ====
`timescale 1ns/10ps

module aligned_ram #(
    parameter int DIN_WIDTH = 32,
    parameter int N_DIN_TO_DOUT = 1,
    parameter int DOUT_ADDR_WIDTH = 8,
    parameter int READ_LATENCY = 2,
    localparam int SLICE_AW = $clog2(N_DIN_TO_DOUT),
    localparam int DOUT_WIDTH = DIN_WIDTH * N_DIN_TO_DOUT,
    localparam int DIN_ADDR_WIDTH = DOUT_ADDR_WIDTH + SLICE_AW
) (
    input  logic                       clk,
    input  logic                       write_enable,
    input  logic [DIN_ADDR_WIDTH-1:0]  write_addr,
    input  logic [DIN_WIDTH-1:0]       write_data,
    input  logic [DOUT_ADDR_WIDTH-1:0] read_addr,
    output logic [DOUT_WIDTH-1:0]      read_data
);

    logic [DOUT_WIDTH-1:0] mem [0:(1 << DOUT_ADDR_WIDTH)-1];
    logic [DOUT_WIDTH-1:0] rd_pipe [0:READ_LATENCY-1];
    logic [DOUT_ADDR_WIDTH-1:0] w_row;
    int unsigned w_slice;

    // upper write address bits pick the row, low bits the slice in it.
    assign w_row = write_addr[DIN_ADDR_WIDTH-1 -: DOUT_ADDR_WIDTH];
    assign w_slice = 32'(write_addr) & (N_DIN_TO_DOUT - 1);

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[w_row][w_slice*DIN_WIDTH +: DIN_WIDTH] <= write_data;
        end
    end

    always_ff @(posedge clk) begin
        rd_pipe[0] <= mem[read_addr];
        for (int i = 1; i < READ_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign read_data = rd_pipe[READ_LATENCY-1];

    // slices must tile the low address bits exactly.
    a_whole_slices: assert property (
        @(posedge clk) (N_DIN_TO_DOUT >= 1) && ((1 << SLICE_AW) == N_DIN_TO_DOUT)
    );

endmodule

// ==== verilog/dac_drive.sv ====
`timescale 1ns/10ps

module dac_drive (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           dac_ready,
    sample_link_if.consumer                link,
    output logic                           dac_valid,
    output logic [dsp_cmd_pkg::WORD_W-1:0] dac_data,
    output logic                           dac_last
);

    logic signed [2*dsp_cmd_pkg::SAMPLE_W-1:0] prod [0:dsp_cmd_pkg::SAMPLES_PER_WORD-1];
    logic [dsp_cmd_pkg::WORD_W-1:0] scaled;
    logic [dsp_cmd_pkg::WORD_W-1:0] s1_data;
    logic s1_last;
    logic s1_valid;
    logic out_free;

    // Q0.15 scaling, keep product bits 30 down to 15.
    always_comb begin
        for (int i = 0; i < dsp_cmd_pkg::SAMPLES_PER_WORD; i++) begin
            prod[i] = $signed(link.data[i*dsp_cmd_pkg::SAMPLE_W +: dsp_cmd_pkg::SAMPLE_W]) *
                      $signed(link.amp);
            scaled[i*dsp_cmd_pkg::SAMPLE_W +: dsp_cmd_pkg::SAMPLE_W] =
                prod[i][2*dsp_cmd_pkg::SAMPLE_W-2 -: dsp_cmd_pkg::SAMPLE_W];
        end
    end

    assign out_free = !dac_valid || dac_ready;
    assign link.credit = dac_valid && dac_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            dac_valid <= 1'b0;
        end else begin
            if (link.valid) begin
                s1_valid <= 1'b1;
            end else if (out_free) begin
                s1_valid <= 1'b0;
            end
            if (out_free) begin
                dac_valid <= s1_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (link.valid) begin
            s1_data <= scaled;
            s1_last <= link.last;
        end
        if (out_free && s1_valid) begin
            dac_data <= s1_data;
            dac_last <= s1_last;
        end
    end

    a_hold_on_stall: assert property (
        @(posedge clk) disable iff (reset)
            dac_valid && !dac_ready |=> dac_valid && $stable(dac_data)
    );

endmodule

// ==== verilog/dsp_cmd_pkg.sv ====
package dsp_cmd_pkg;

    localparam int SAMPLE_W = 16;
    localparam int SAMPLES_PER_WORD = 4;
    localparam int WORD_W = SAMPLE_W * SAMPLES_PER_WORD;

    // amplitude is unsigned Q0.15 with the top bit zero.
    localparam int AMP_W = 16;

    typedef enum logic [1:0] {
        OP_PLAY = 2'd0,
        OP_WAIT = 2'd1,
        OP_END  = 2'd2
    } opcode_e;

    // one command word, read as play or as wait. the opcode sits on top in both.
    typedef union packed {
        struct packed {
            opcode_e     op;
            logic [8:0]  env_addr;
            logic [6:0]  len_words;
            logic [13:0] amp;
        } play;
        struct packed {
            opcode_e     op;
            logic [29:0] wait_cycles;
        } delay;
    } cmd_word_u;

    // credit counters and FIFO sizing.
    localparam int FIFO_AW = 3;
    localparam int CREDIT_W = 4;
    localparam logic [CREDIT_W-1:0] FIFO_DEPTH = 4'd8;
    localparam logic [CREDIT_W-1:0] DAC_CREDITS = 4'd2;

    // sequencer FSM states.
    localparam logic [2:0] SEQ_IDLE  = 3'd0;
    localparam logic [2:0] SEQ_FETCH = 3'd1;
    localparam logic [2:0] SEQ_PLAY  = 3'd2;
    localparam logic [2:0] SEQ_WAIT  = 3'd3;
    localparam logic [2:0] SEQ_DRAIN = 3'd4;

endpackage

// ==== verilog/dsp_core.sv ====
`timescale 1ns/10ps

module dsp_core (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               stb_start,
    input  logic                               mem_write_en,
    input  logic [dsp_mem_pkg::MEM_SEL_W-1:0]  mem_write_sel,
    input  logic [dsp_mem_pkg::MEM_ADDR_W-1:0] mem_write_addr,
    input  logic [dsp_mem_pkg::MEM_DATA_W-1:0] mem_write_data,
    input  logic                               dac_ready,
    output logic                               dac_valid,
    output logic [dsp_cmd_pkg::WORD_W-1:0]     dac_data,
    output logic                               dac_last,
    output logic                               done
);

    logic cmd_wen;
    logic env_wen;
    logic [dsp_mem_pkg::CMD_ADDRWIDTH-1:0] cmd_addr;
    logic [dsp_mem_pkg::MEM_DATA_W-1:0] cmd_data;
    logic [dsp_mem_pkg::ENV_R_ADDRWIDTH-1:0] env_addr;
    logic [dsp_cmd_pkg::WORD_W-1:0] env_data;
    logic fifo_idle;

    sample_link_if seq_link ();
    sample_link_if dac_link ();

    assign cmd_wen = mem_write_en && (mem_write_sel == dsp_mem_pkg::MEM_SEL_CMD);
    assign env_wen = mem_write_en && (mem_write_sel == dsp_mem_pkg::MEM_SEL_ENV);

    aligned_ram #(
        .DIN_WIDTH(dsp_mem_pkg::MEM_DATA_W),
        .N_DIN_TO_DOUT(1),
        .DOUT_ADDR_WIDTH(dsp_mem_pkg::CMD_ADDRWIDTH),
        .READ_LATENCY(dsp_mem_pkg::RAM_READ_LATENCY)
    ) cmd_mem (
        .clk(clk),
        .write_enable(cmd_wen),
        .write_addr(mem_write_addr[dsp_mem_pkg::CMD_ADDRWIDTH-1:0]),
        .write_data(mem_write_data),
        .read_addr(cmd_addr),
        .read_data(cmd_data)
    );

    aligned_ram #(
        .DIN_WIDTH(dsp_mem_pkg::MEM_DATA_W),
        .N_DIN_TO_DOUT(dsp_mem_pkg::ENV_N_DIN_TO_DOUT),
        .DOUT_ADDR_WIDTH(dsp_mem_pkg::ENV_R_ADDRWIDTH),
        .READ_LATENCY(dsp_mem_pkg::RAM_READ_LATENCY)
    ) env_mem (
        .clk(clk),
        .write_enable(env_wen),
        .write_addr(mem_write_addr[dsp_mem_pkg::ENV_W_ADDRWIDTH-1:0]),
        .write_data(mem_write_data),
        .read_addr(env_addr),
        .read_data(env_data)
    );

    pulse_sequencer seq_i (
        .clk(clk),
        .reset(reset),
        .stb_start(stb_start),
        .cmd_data(cmd_data),
        .env_data(env_data),
        .fifo_done_idle(fifo_idle),
        .cmd_addr(cmd_addr),
        .env_addr(env_addr),
        .done(done),
        .link(seq_link.producer)
    );

    sample_fifo fifo_i (
        .clk(clk),
        .reset(reset),
        .link_in(seq_link.consumer),
        .link_out(dac_link.producer),
        .idle(fifo_idle)
    );

    dac_drive dac_i (
        .clk(clk),
        .reset(reset),
        .dac_ready(dac_ready),
        .link(dac_link.consumer),
        .dac_valid(dac_valid),
        .dac_data(dac_data),
        .dac_last(dac_last)
    );

endmodule

// ==== verilog/dsp_mem_pkg.sv ====
package dsp_mem_pkg;

    // host write port.
    localparam int MEM_SEL_W = 3;
    localparam int MEM_ADDR_W = 16;
    localparam int MEM_DATA_W = 32;

    // write selector codes.
    localparam logic [MEM_SEL_W-1:0] MEM_SEL_CMD = 3'd0;
    localparam logic [MEM_SEL_W-1:0] MEM_SEL_ENV = 3'd1;

    // command memory, one 32-bit write word per read word.
    localparam int CMD_ADDRWIDTH = 8;

    // envelope memory, two 32-bit writes make one 64-bit read word.
    localparam int ENV_W_ADDRWIDTH = 10;
    localparam int ENV_R_ADDRWIDTH = 9;
    localparam int ENV_N_DIN_TO_DOUT = 2;

    // cycles from read address to read data.
    localparam int RAM_READ_LATENCY = 2;

endpackage

// ==== verilog/pulse_sequencer.sv ====
`timescale 1ns/10ps

module pulse_sequencer (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic                                    stb_start,
    input  dsp_cmd_pkg::cmd_word_u                  cmd_data,
    input  logic [dsp_cmd_pkg::WORD_W-1:0]          env_data,
    input  logic                                    fifo_done_idle,
    output logic [dsp_mem_pkg::CMD_ADDRWIDTH-1:0]   cmd_addr,
    output logic [dsp_mem_pkg::ENV_R_ADDRWIDTH-1:0] env_addr,
    output logic                                    done,
    sample_link_if.producer                         link
);

    logic [2:0] state;
    logic [dsp_mem_pkg::RAM_READ_LATENCY-1:0] fetch_pipe;
    logic [dsp_mem_pkg::RAM_READ_LATENCY-1:0] iss_v;
    logic [dsp_mem_pkg::RAM_READ_LATENCY-1:0] iss_last;
    logic [7:0] words_left;
    logic [29:0] wait_cnt;
    logic [dsp_cmd_pkg::CREDIT_W-1:0] credit_cnt;
    logic [dsp_cmd_pkg::CREDIT_W-1:0] inflight;
    logic [dsp_cmd_pkg::AMP_W-1:0] amp_r;
    logic decode;
    logic issue;
    logic ret;

    assign decode = (state == dsp_cmd_pkg::SEQ_FETCH) &&
                    fetch_pipe[dsp_mem_pkg::RAM_READ_LATENCY-1];

    // a read goes out only while a FIFO slot is left that no earlier read has claimed.
    assign issue = (state == dsp_cmd_pkg::SEQ_PLAY) && (words_left != 8'd0) &&
                   (credit_cnt > inflight);
    assign ret = iss_v[dsp_mem_pkg::RAM_READ_LATENCY-1];

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dsp_cmd_pkg::SEQ_IDLE;
            done <= 1'b0;
            cmd_addr <= '0;
            env_addr <= '0;
            fetch_pipe <= '0;
            words_left <= '0;
            wait_cnt <= '0;
        end else begin
            case (state)
                dsp_cmd_pkg::SEQ_IDLE: begin
                    if (stb_start) begin
                        done <= 1'b0;
                        cmd_addr <= '0;
                        fetch_pipe <= '0;
                        state <= dsp_cmd_pkg::SEQ_FETCH;
                    end
                end
                dsp_cmd_pkg::SEQ_FETCH: begin
                    fetch_pipe <= (fetch_pipe << 1) | 1'b1;
                    if (decode) begin
                        cmd_addr <= cmd_addr + 1'b1;
                        fetch_pipe <= '0;
                        case (cmd_data.play.op)
                            dsp_cmd_pkg::OP_PLAY: begin
                                env_addr <= cmd_data.play.env_addr;
                                // length 0 stands for 128 words.
                                words_left <= {cmd_data.play.len_words == 7'd0,
                                               cmd_data.play.len_words};
                                state <= dsp_cmd_pkg::SEQ_PLAY;
                            end
                            dsp_cmd_pkg::OP_WAIT: begin
                                wait_cnt <= cmd_data.delay.wait_cycles;
                                state <= dsp_cmd_pkg::SEQ_WAIT;
                            end
                            dsp_cmd_pkg::OP_END: state <= dsp_cmd_pkg::SEQ_DRAIN;
                            default: state <= dsp_cmd_pkg::SEQ_IDLE;
                        endcase
                    end
                end
                dsp_cmd_pkg::SEQ_PLAY: begin
                    if (issue) begin
                        env_addr <= env_addr + 1'b1;
                        words_left <= words_left - 1'b1;
                    end else if (words_left == 8'd0 && inflight == '0) begin
                        state <= dsp_cmd_pkg::SEQ_FETCH;
                    end
                end
                dsp_cmd_pkg::SEQ_WAIT: begin
                    wait_cnt <= wait_cnt - 1'b1;
                    if (wait_cnt <= 30'd1) begin
                        state <= dsp_cmd_pkg::SEQ_FETCH;
                    end
                end
                dsp_cmd_pkg::SEQ_DRAIN: begin
                    // all credits home means nothing is left downstream.
                    if (fifo_done_idle && credit_cnt == dsp_cmd_pkg::FIFO_DEPTH) begin
                        done <= 1'b1;
                        state <= dsp_cmd_pkg::SEQ_IDLE;
                    end
                end
                default: state <= dsp_cmd_pkg::SEQ_IDLE;
            endcase
        end
    end

    // read tracking and credit accounting.
    always_ff @(posedge clk) begin
        if (reset) begin
            iss_v <= '0;
            link.valid <= 1'b0;
            credit_cnt <= dsp_cmd_pkg::FIFO_DEPTH;
            inflight <= '0;
        end else begin
            iss_v <= (iss_v << 1) | issue;
            link.valid <= ret;
            case ({link.valid, link.credit})
                2'b10: credit_cnt <= credit_cnt - 1'b1;
                2'b01: credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
            case ({issue, link.valid})
                2'b10: inflight <= inflight + 1'b1;
                2'b01: inflight <= inflight - 1'b1;
                default: inflight <= inflight;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        iss_last <= (iss_last << 1) | (issue && words_left == 8'd1);
        if (decode) begin
            amp_r <= {2'b00, cmd_data.play.amp};
        end
        if (ret) begin
            link.data <= env_data;
            link.amp <= amp_r;
            link.last <= iss_last[dsp_mem_pkg::RAM_READ_LATENCY-1];
        end
    end

    a_credit_max: assert property (
        @(posedge clk) disable iff (reset) credit_cnt <= dsp_cmd_pkg::FIFO_DEPTH
    );

endmodule

// ==== verilog/sample_fifo.sv ====
`timescale 1ns/10ps

module sample_fifo (
    input  logic            clk,
    input  logic            reset,
    sample_link_if.consumer link_in,
    sample_link_if.producer link_out,
    output logic            idle
);

    logic [dsp_cmd_pkg::WORD_W-1:0] data_mem [0:dsp_cmd_pkg::FIFO_DEPTH-1];
    logic [dsp_cmd_pkg::AMP_W-1:0]  amp_mem [0:dsp_cmd_pkg::FIFO_DEPTH-1];
    logic                           last_mem [0:dsp_cmd_pkg::FIFO_DEPTH-1];
    logic [dsp_cmd_pkg::FIFO_AW-1:0] wr_ptr;
    logic [dsp_cmd_pkg::FIFO_AW-1:0] rd_ptr;
    logic [dsp_cmd_pkg::CREDIT_W-1:0] count;
    logic [dsp_cmd_pkg::CREDIT_W-1:0] dac_cnt;
    logic send;

    assign send = (count != '0) && (dac_cnt != '0);

    assign link_out.valid = send;
    assign link_out.data = data_mem[rd_ptr];
    assign link_out.amp = amp_mem[rd_ptr];
    assign link_out.last = last_mem[rd_ptr];

    // a slot frees as soon as its word moves on.
    assign link_in.credit = send;

    assign idle = (count == '0) && (dac_cnt == dsp_cmd_pkg::DAC_CREDITS);

    always_ff @(posedge clk) begin
        if (link_in.valid) begin
            data_mem[wr_ptr] <= link_in.data;
            amp_mem[wr_ptr] <= link_in.amp;
            last_mem[wr_ptr] <= link_in.last;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            dac_cnt <= dsp_cmd_pkg::DAC_CREDITS;
        end else begin
            if (link_in.valid) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (send) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({link_in.valid, send})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({send, link_out.credit})
                2'b10: dac_cnt <= dac_cnt - 1'b1;
                2'b01: dac_cnt <= dac_cnt + 1'b1;
                default: dac_cnt <= dac_cnt;
            endcase
        end
    end

    // the sequencer's credits must keep it from pushing into a full buffer.
    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset)
            link_in.valid |-> (count < dsp_cmd_pkg::FIFO_DEPTH)
    );

endmodule

// ==== verilog/sample_link_if.sv ====
`timescale 1ns/10ps

interface sample_link_if;

    logic                           valid;
    logic [dsp_cmd_pkg::WORD_W-1:0] data;
    logic [dsp_cmd_pkg::AMP_W-1:0]  amp;
    logic                           last;
    // one pulse per freed slot in the receiver.
    logic                           credit;

    modport producer (
        output valid, data, amp, last,
        input  credit
    );

    modport consumer (
        input  valid, data, amp, last,
        output credit
    );

endinterface
